// File: rtl/hostPkg.sv
/*
 * Processor bus and register map definitions for the output shell.
 * The bus is a strobe bus sampled on ck933 with a fixed one-cycle read
 * latency and no wait states. Registers are 32 bits and are read as
 * two 16-bit halves. Address bit 1 picks the upper half and bit 0 is unused.
 */
package hostPkg;

    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 16;

    // One processor bus cycle
    typedef struct packed {
        logic                  cs;
        logic                  rd;
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wrData;
    } busReq_t;

    // ****************************************
    // Address map
    // ****************************************

    // Space codes in addr[11:6]
    localparam logic [5:0] MISC_SPACE   = 6'h3F;
    localparam logic [5:0] CONFIG_SPACE = 6'h01;

    // Word offsets in addr[5:2]
    localparam logic [3:0] MISC_VERSION = 4'd0;
    localparam logic [3:0] MISC_CLOCK   = 4'd1;
    localparam logic [3:0] MISC_RESET   = 4'd2;

    localparam logic [3:0] CFG_MODE = 4'd0;
    localparam logic [3:0] CFG_DAC0 = 4'd1;
    localparam logic [3:0] CFG_DAC1 = 4'd2;
    localparam logic [3:0] CFG_DAC2 = 4'd3;

    // Misc space access after space decode
    typedef struct packed {
        logic                  wrEn;
        logic                  rdEn;
        logic [3:0]            offset;
        logic [DATA_WIDTH-1:0] wrData;
    } miscAccess_t;

    localparam logic [15:0] VERSION_NUMBER = 16'h0144;

    // Software reset pulse length in ck933 cycles
    localparam int RESET_STRETCH = 6;

endpackage

// File: rtl/demodPkg.sv
/*
 * Demodulator side types for the output shell.
 * Mode codes follow the software register encoding.
 * DAC select codes C to F are the trellis views. All other codes
 * come from the multi-h loop or the plain demodulator.
 */
package demodPkg;

    localparam int SAMPLE_WIDTH = 18;
    localparam int DAC_WIDTH    = 14;

    typedef enum logic [3:0] {
        MODE_AM         = 4'd0,
        MODE_PM         = 4'd1,
        MODE_FM         = 4'd2,
        MODE_2FSK       = 4'd3,
        MODE_BPSK       = 4'd4,
        MODE_QPSK       = 4'd5,
        MODE_PCMTRELLIS = 4'd6,
        MODE_SOQPSK     = 4'd7,
        MODE_MULTIH     = 4'd8
    } demodMode_t;

    typedef logic [3:0] dacSelect_t;

    // ****************************************
    // Trellis DAC views
    // ****************************************
    localparam dacSelect_t DAC_TRELLIS_I     = 4'hC;
    localparam dacSelect_t DAC_TRELLIS_Q     = 4'hD;
    localparam dacSelect_t DAC_TRELLIS_PHERR = 4'hE;
    localparam dacSelect_t DAC_TRELLIS_INDEX = 4'hF;

    // 16-bit config register contents
    typedef struct packed {
        demodMode_t            mode;
        dacSelect_t [2:0]      dacSelect;
    } demodConfig_t;

    // Bit-sync output of the legacy demodulator
    typedef struct packed {
        logic symEn;
        logic sym2xEn;
        logic iBit;
        logic qBit;
    } legacyStream_t;

    typedef struct packed {
        logic symEn;
        logic sym2xEn;
        logic decision;
    } trellisStream_t;

    typedef struct packed {
        logic symEn;
        logic sym2xEn;
        logic iData;
        logic qData;
    } dataOut_t;

    typedef struct packed {
        logic                    sync;
        logic [SAMPLE_WIDTH-1:0] data;
    } dacSample_t;

    typedef struct packed {
        dacSample_t sample;
        logic       en;
    } multihSample_t;

    typedef struct packed {
        logic bitsyncLock;
        logic carrierLock;
        logic multihLock;
    } lockStatus_t;

    typedef struct packed {
        logic bitsyncUnlocked;
        logic demodUnlocked;
    } lockOut_t;

endpackage

// File: rtl/hostRegs.sv
/*
 * Bus decode, config registers and registered read data.
 * rdData is valid one cycle after a read cycle and is zero after any
 * other cycle or after a read of an unmapped address.
 * Config values read back in the low half with zero in the high half.
 */
`timescale 1ns/1ns

module hostRegs (
    input  logic                           ck933,
    input  logic                           clockCounterEn,
    input  hostPkg::busReq_t               busReq,
    input  logic [31:0]                    miscRdData,
    output hostPkg::miscAccess_t           miscAccess,
    output demodPkg::demodConfig_t         demodConfig,
    output logic [hostPkg::DATA_WIDTH-1:0] rdData
);

    logic [5:0]  space;
    logic [3:0]  offset;
    logic        hiHalf;
    logic        wrCycle;
    logic        rdCycle;
    logic [31:0] cfgWord;
    logic [31:0] rdWord;

    assign space   = busReq.addr[11:6];
    assign offset  = busReq.addr[5:2];
    assign hiHalf  = busReq.addr[1];
    assign wrCycle = busReq.cs & busReq.we;
    assign rdCycle = busReq.cs & busReq.rd;

    // Misc space goes straight through
    assign miscAccess.wrEn   = wrCycle && (space == hostPkg::MISC_SPACE);
    assign miscAccess.rdEn   = rdCycle && (space == hostPkg::MISC_SPACE);
    assign miscAccess.offset = offset;
    assign miscAccess.wrData = busReq.wrData;

    // ****************************************
    // Config writes
    // ****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodConfig <= '0;
        end else if (wrCycle && (space == hostPkg::CONFIG_SPACE)) begin
            case (offset)
                hostPkg::CFG_MODE: begin
                    demodConfig.mode <= demodPkg::demodMode_t'(busReq.wrData[3:0]);
                end
                hostPkg::CFG_DAC0: demodConfig.dacSelect[0] <= busReq.wrData[3:0];
                hostPkg::CFG_DAC1: demodConfig.dacSelect[1] <= busReq.wrData[3:0];
                hostPkg::CFG_DAC2: demodConfig.dacSelect[2] <= busReq.wrData[3:0];
                default: ;
            endcase
        end
    end

    // ****************************************
    // Read mux
    // ****************************************
    always_comb begin
        cfgWord = '0;
        case (offset)
            hostPkg::CFG_MODE: cfgWord[3:0] = demodConfig.mode;
            hostPkg::CFG_DAC0: cfgWord[3:0] = demodConfig.dacSelect[0];
            hostPkg::CFG_DAC1: cfgWord[3:0] = demodConfig.dacSelect[1];
            hostPkg::CFG_DAC2: cfgWord[3:0] = demodConfig.dacSelect[2];
            default:           cfgWord      = '0;
        endcase

        // Unmapped spaces read zero
        if (space == hostPkg::MISC_SPACE) begin
            rdWord = miscRdData;
        end else if (space == hostPkg::CONFIG_SPACE) begin
            rdWord = cfgWord;
        end else begin
            rdWord = '0;
        end
    end

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rdData <= '0;
        end else if (!rdCycle) begin
            rdData <= '0;
        end else if (hiHalf) begin
            rdData <= rdWord[31:16];
        end else begin
            rdData <= rdWord[15:0];
        end
    end

endmodule

// File: rtl/miscSpace.sv
/*
 * Version word, clock counter and software reset.
 * The counter restarts on a MISC_CLOCK write and any MISC_CLOCK read
 * captures the full count. The low half reads the live count and the
 * high half reads the captured count.
 * A MISC_RESET write holds coreReset for RESET_STRETCH cycles.
 */
`timescale 1ns/1ns

module miscSpace (
    input  logic                 ck933,
    input  logic                 clockCounterEn,
    input  hostPkg::miscAccess_t miscAccess,
    output logic [31:0]          miscRdData,
    output logic                 coreReset
);

    typedef logic [$clog2(hostPkg::RESET_STRETCH + 1)-1:0] stretch_t;

    logic [31:0] clockCounter;
    logic [31:0] clockHold;
    stretch_t    stretchCount;
    logic        clockWrite;
    logic        clockRead;
    logic        resetWrite;

    assign clockWrite = miscAccess.wrEn && (miscAccess.offset == hostPkg::MISC_CLOCK);
    assign clockRead  = miscAccess.rdEn && (miscAccess.offset == hostPkg::MISC_CLOCK);
    assign resetWrite = miscAccess.wrEn && (miscAccess.offset == hostPkg::MISC_RESET);

    // ****************************************
    // Clock counter
    // ****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCounter <= '0;
            clockHold    <= '0;
        end else begin
            if (clockWrite) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 32'd1;
            end
            // Snapshot for the following high half read
            if (clockRead) begin
                clockHold <= clockCounter;
            end
        end
    end

    // ****************************************
    // Software reset stretch
    // ****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            stretchCount <= '0;
        end else if (resetWrite) begin
            stretchCount <= stretch_t'(hostPkg::RESET_STRETCH);
        end else if (stretchCount != '0) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    assign coreReset = (stretchCount != '0);

    // Read word at the addressed offset
    always_comb begin
        case (miscAccess.offset)
            hostPkg::MISC_VERSION: miscRdData = {hostPkg::VERSION_NUMBER, 16'h0000};
            hostPkg::MISC_CLOCK:   miscRdData = {clockHold[31:16], clockCounter[15:0]};
            default:               miscRdData = '0;
        endcase
    end

endmodule

// File: rtl/dataOutputSelect.sv
/*
 * Data bit and lock output selection.
 * Trellis modes (PCM and SOQPSK) have two cycles of latency and all
 * other modes one. The PCM decision is inverted, as is the legacy I bit
 * in FM and 2FSK. coreReset clears every register synchronously.
 */
`timescale 1ns/1ns

module dataOutputSelect (
    input  logic                     ck933,
    input  logic                     clockCounterEn,
    input  logic                     coreReset,
    input  demodPkg::demodMode_t     mode,
    input  demodPkg::legacyStream_t  legacy,
    input  demodPkg::trellisStream_t pcmTrellis,
    input  demodPkg::trellisStream_t soqpskTrellis,
    input  demodPkg::lockStatus_t    lockStatus,
    output demodPkg::dataOut_t       dataOut,
    output demodPkg::lockOut_t       lockOut
);

    logic                     pcmMode;
    logic                     trellisMode;
    logic                     fmMode;
    logic                     multihMode;
    demodPkg::trellisStream_t trellisSel;

    assign pcmMode     = (mode == demodPkg::MODE_PCMTRELLIS);
    assign trellisMode = pcmMode || (mode == demodPkg::MODE_SOQPSK);
    assign fmMode      = (mode == demodPkg::MODE_FM) || (mode == demodPkg::MODE_2FSK);
    assign multihMode  = (mode == demodPkg::MODE_MULTIH);

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisSel <= '0;
            dataOut    <= '0;
            lockOut    <= '0;
        end else if (coreReset) begin
            trellisSel <= '0;
            dataOut    <= '0;
            lockOut    <= '0;
        end else begin
            // Stage one picks the trellis decoder
            if (pcmMode) begin
                trellisSel.symEn    <= pcmTrellis.symEn;
                trellisSel.sym2xEn  <= pcmTrellis.sym2xEn;
                trellisSel.decision <= ~pcmTrellis.decision;
            end else begin
                trellisSel <= soqpskTrellis;
            end

            // Stage two picks trellis or legacy bits
            if (trellisMode) begin
                dataOut.symEn   <= trellisSel.symEn;
                dataOut.sym2xEn <= trellisSel.sym2xEn;
                dataOut.iData   <= trellisSel.decision;
                dataOut.qData   <= trellisSel.decision;
            end else begin
                dataOut.symEn   <= legacy.symEn;
                dataOut.sym2xEn <= legacy.sym2xEn;
                dataOut.iData   <= fmMode ? ~legacy.iBit : legacy.iBit;
                dataOut.qData   <= legacy.qBit;
            end

            // Active high unlock indications
            lockOut.bitsyncUnlocked <= ~lockStatus.bitsyncLock;
            lockOut.demodUnlocked   <= multihMode ? ~lockStatus.multihLock
                                                  : ~lockStatus.carrierLock;
        end
    end

endmodule

// File: rtl/dacChannelMux.sv
/*
 * Source selection for one DAC channel.
 * Trellis codes take the active trellis decoder. Otherwise the multi-h
 * view is used when enabled in multi-h mode, else the demod sample.
 * The output holds the top DAC_WIDTH bits and updates only on sync.
 */
`timescale 1ns/1ns

module dacChannelMux (
    input  logic                              ck933,
    input  logic                              clockCounterEn,
    input  logic                              coreReset,
    input  demodPkg::demodMode_t              mode,
    input  demodPkg::dacSelect_t              select,
    input  demodPkg::dacSample_t              demodIn,
    input  demodPkg::dacSample_t              pcmIn,
    input  demodPkg::dacSample_t              soqpskIn,
    input  demodPkg::multihSample_t           multihIn,
    output logic [demodPkg::DAC_WIDTH-1:0]    dacData
);

    logic                 trellisSelect;
    demodPkg::dacSample_t chosen;
    demodPkg::dacSample_t chosenReg;

    assign trellisSelect = select inside {demodPkg::DAC_TRELLIS_I, demodPkg::DAC_TRELLIS_Q,
                                          demodPkg::DAC_TRELLIS_PHERR,
                                          demodPkg::DAC_TRELLIS_INDEX};

    always_comb begin
        if (trellisSelect) begin
            chosen = (mode == demodPkg::MODE_PCMTRELLIS) ? pcmIn : soqpskIn;
        end else if (multihIn.en && (mode == demodPkg::MODE_MULTIH)) begin
            chosen = multihIn.sample;
        end else begin
            chosen = demodIn;
        end
    end

    // Select register, then sync-gated output register
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            chosenReg <= '0;
            dacData   <= '0;
        end else if (coreReset) begin
            chosenReg <= '0;
            dacData   <= '0;
        end else begin
            chosenReg <= chosen;
            if (chosenReg.sync) begin
                dacData <= chosenReg.data[demodPkg::SAMPLE_WIDTH-1 -: demodPkg::DAC_WIDTH];
            end
        end
    end

endmodule

// File: rtl/demodOutputShell.sv
/*
 * Host interface and output routing around the demodulator.
 * Demodulator, trellis and multi-h outputs arrive on ports.
 * clockCounterEn is an asynchronous reset for the whole shell and
 * coreReset is the stretched software reset of the data paths.
 */
`timescale 1ns/1ns

module demodOutputShell (
    input  logic                           ck933,
    input  logic                           clockCounterEn,
    input  hostPkg::busReq_t               busReq,
    output logic [hostPkg::DATA_WIDTH-1:0] rdData,
    input  demodPkg::legacyStream_t        legacy,
    input  demodPkg::trellisStream_t       pcmTrellis,
    input  demodPkg::trellisStream_t       soqpskTrellis,
    input  demodPkg::lockStatus_t          lockStatus,
    input  demodPkg::dacSample_t           demodSample [3],
    input  demodPkg::dacSample_t           pcmTrellisSample [3],
    input  demodPkg::dacSample_t           soqpskTrellisSample [3],
    input  demodPkg::multihSample_t        multihSample [3],
    output demodPkg::dataOut_t             dataOut,
    output demodPkg::lockOut_t             lockOut,
    output demodPkg::demodMode_t           demodMode,
    output logic                           coreReset,
    output logic [demodPkg::DAC_WIDTH-1:0] dacData [3]
);

    hostPkg::miscAccess_t   miscAccess;
    logic [31:0]            miscRdData;
    demodPkg::demodConfig_t demodConfig;

    assign demodMode = demodConfig.mode;

    // ****************************************
    // Register bus
    // ****************************************
    hostRegs hostRegs (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .busReq         (busReq),
        .miscRdData     (miscRdData),
        .miscAccess     (miscAccess),
        .demodConfig    (demodConfig),
        .rdData         (rdData)
    );

    miscSpace miscSpace (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .miscAccess     (miscAccess),
        .miscRdData     (miscRdData),
        .coreReset      (coreReset)
    );

    // ****************************************
    // Output routing
    // ****************************************
    dataOutputSelect dataOutputSelect (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .coreReset      (coreReset),
        .mode           (demodConfig.mode),
        .legacy         (legacy),
        .pcmTrellis     (pcmTrellis),
        .soqpskTrellis  (soqpskTrellis),
        .lockStatus     (lockStatus),
        .dataOut        (dataOut),
        .lockOut        (lockOut)
    );

    for (genvar i = 0; i < 3; i++) begin : gDac
        dacChannelMux dacChannel (
            .ck933          (ck933),
            .clockCounterEn (clockCounterEn),
            .coreReset      (coreReset),
            .mode           (demodConfig.mode),
            .select         (demodConfig.dacSelect[i]),
            .demodIn        (demodSample[i]),
            .pcmIn          (pcmTrellisSample[i]),
            .soqpskIn       (soqpskTrellisSample[i]),
            .multihIn       (multihSample[i]),
            .dacData        (dacData[i])
        );
    end

endmodule

// File: tb/demodShellModel.svh
/*
 * Cycle model of the output shell, included inside the testbench module.
 * stepModel runs once per rising edge, just after it, on the inputs that
 * edge sampled. Needs EXP_VERSION, STRETCH_CYCLES and the DUT input
 * signals to be declared before the include.
 */
`ifndef DEMOD_SHELL_MODEL_SVH
`define DEMOD_SHELL_MODEL_SVH

// Everything the shell saw at one rising edge
typedef struct packed {
    logic                          rst;
    demodPkg::demodConfig_t        cfg;
    demodPkg::legacyStream_t       legacy;
    demodPkg::trellisStream_t      pcm;
    demodPkg::trellisStream_t      soqpsk;
    demodPkg::lockStatus_t         lock;
    demodPkg::dacSample_t [2:0]    demodS;
    demodPkg::dacSample_t [2:0]    pcmS;
    demodPkg::dacSample_t [2:0]    soqpskS;
    demodPkg::multihSample_t [2:0] multihS;
} edgeSnap_t;

edgeSnap_t              snapNow;
edgeSnap_t              snapPrev;
demodPkg::demodConfig_t modelCfg;
int                     resetLeft;
int                     cycleNum;
int                     restartCycle;
logic [31:0]            clockHold;
logic [15:0]            expRdData;
demodPkg::dataOut_t     expDataOut;
demodPkg::lockOut_t     expLockOut;
logic [13:0]            expDac [3];

task automatic resetModel();
    snapNow      = '0;
    snapNow.rst  = 1'b1;
    snapPrev     = snapNow;
    modelCfg     = '0;
    resetLeft    = 0;
    cycleNum     = 0;
    restartCycle = 0;
    clockHold    = '0;
    expRdData    = '0;
    expDataOut   = '0;
    expLockOut   = '0;
    for (int ch = 0; ch < 3; ch++) begin
        expDac[ch] = '0;
    end
endtask

// Source sample a DAC channel picks at one edge
function automatic demodPkg::dacSample_t dacSource(input edgeSnap_t s, input int ch);
    demodPkg::demodMode_t m;
    m = s.cfg.mode;
    if (s.rst) begin
        return '0;
    end else if (s.cfg.dacSelect[ch] >= 4'hC) begin
        return (m == demodPkg::MODE_PCMTRELLIS) ? s.pcmS[ch] : s.soqpskS[ch];
    end else if (s.multihS[ch].en && (m == demodPkg::MODE_MULTIH)) begin
        return s.multihS[ch].sample;
    end
    return s.demodS[ch];
endfunction

task automatic stepModel();
    logic [31:0]              count;
    logic [31:0]              word;
    logic [5:0]               space;
    logic [3:0]               offset;
    logic                     rdCycle;
    logic                     fmInvert;
    demodPkg::trellisStream_t tr;
    demodPkg::dacSample_t     src;
    demodPkg::demodMode_t     m;
    cycleNum++;
    snapPrev       = snapNow;
    snapNow.rst    = (resetLeft > 0);
    snapNow.cfg    = modelCfg;
    snapNow.legacy = legacy;
    snapNow.pcm    = pcmTrellis;
    snapNow.soqpsk = soqpskTrellis;
    snapNow.lock   = lockStatus;
    for (int ch = 0; ch < 3; ch++) begin
        snapNow.demodS[ch]  = demodSample[ch];
        snapNow.pcmS[ch]    = pcmTrellisSample[ch];
        snapNow.soqpskS[ch] = soqpskTrellisSample[ch];
        snapNow.multihS[ch] = multihSample[ch];
    end

    // ****************************************
    // Register bus
    // ****************************************
    space   = busReq.addr[11:6];
    offset  = busReq.addr[5:2];
    rdCycle = busReq.cs && busReq.rd;
    count   = cycleNum - restartCycle - 1;
    word    = '0;
    if (space == hostPkg::MISC_SPACE && offset == hostPkg::MISC_VERSION) begin
        word = {EXP_VERSION, 16'h0000};
    end else if (space == hostPkg::MISC_SPACE && offset == hostPkg::MISC_CLOCK) begin
        word = {clockHold[31:16], count[15:0]};
    end else if (space == hostPkg::CONFIG_SPACE) begin
        case (offset)
            hostPkg::CFG_MODE: word[3:0] = modelCfg.mode;
            hostPkg::CFG_DAC0: word[3:0] = modelCfg.dacSelect[0];
            hostPkg::CFG_DAC1: word[3:0] = modelCfg.dacSelect[1];
            hostPkg::CFG_DAC2: word[3:0] = modelCfg.dacSelect[2];
            default:           word      = '0;
        endcase
    end
    expRdData = !rdCycle ? 16'h0000 : (busReq.addr[1] ? word[31:16] : word[15:0]);
    if (rdCycle && space == hostPkg::MISC_SPACE && offset == hostPkg::MISC_CLOCK) begin
        clockHold = count;
    end
    if (resetLeft > 0) begin
        resetLeft--;
    end
    if (busReq.cs && busReq.we && space == hostPkg::MISC_SPACE) begin
        if (offset == hostPkg::MISC_CLOCK) begin
            restartCycle = cycleNum;
        end
        if (offset == hostPkg::MISC_RESET) begin
            resetLeft = STRETCH_CYCLES;
        end
    end
    if (busReq.cs && busReq.we && space == hostPkg::CONFIG_SPACE) begin
        case (offset)
            hostPkg::CFG_MODE: modelCfg.mode = demodPkg::demodMode_t'(busReq.wrData[3:0]);
            hostPkg::CFG_DAC0: modelCfg.dacSelect[0] = busReq.wrData[3:0];
            hostPkg::CFG_DAC1: modelCfg.dacSelect[1] = busReq.wrData[3:0];
            hostPkg::CFG_DAC2: modelCfg.dacSelect[2] = busReq.wrData[3:0];
            default: ;
        endcase
    end

    // ****************************************
    // Data, lock and DAC outputs
    // ****************************************
    m        = snapNow.cfg.mode;
    fmInvert = (m == demodPkg::MODE_FM || m == demodPkg::MODE_2FSK);
    if (snapNow.rst) begin
        expDataOut = '0;
        expLockOut = '0;
    end else begin
        if (m == demodPkg::MODE_PCMTRELLIS || m == demodPkg::MODE_SOQPSK) begin
            // Trellis bits come from the edge before
            tr = snapPrev.soqpsk;
            if (snapPrev.cfg.mode == demodPkg::MODE_PCMTRELLIS) begin
                tr = {snapPrev.pcm.symEn, snapPrev.pcm.sym2xEn, ~snapPrev.pcm.decision};
            end
            if (snapPrev.rst) begin
                tr = '0;
            end
            expDataOut = {tr.symEn, tr.sym2xEn, tr.decision, tr.decision};
        end else begin
            expDataOut = {snapNow.legacy.symEn, snapNow.legacy.sym2xEn,
                          snapNow.legacy.iBit ^ fmInvert,
                          snapNow.legacy.qBit};
        end
        expLockOut = {~snapNow.lock.bitsyncLock,
                      (m == demodPkg::MODE_MULTIH) ? ~snapNow.lock.multihLock
                                                   : ~snapNow.lock.carrierLock};
    end
    for (int ch = 0; ch < 3; ch++) begin
        src = dacSource(snapPrev, ch);
        if (snapNow.rst) begin
            expDac[ch] = '0;
        end else if (src.sync) begin
            expDac[ch] = src.data[17:4];
        end
    end
endtask

`endif

// File: tb/demodShellTb.sv
/*
 * Testbench for demodOutputShell.
 * Random streams from a fixed seed change every cycle and a cycle model
 * checks every output 1 ns after each rising edge, when inputs also change.
 * Register reads assume no wait states. The run stops at CYCLE_LIMIT cycles.
 */
`timescale 1ns/1ns

module demodShellTb;

    localparam int          CYCLE_LIMIT    = 5000;
    localparam logic [15:0] EXP_VERSION    = 16'h0144;
    localparam int          STRETCH_CYCLES = 6;

    logic                     ck933 = 1'b0;
    logic                     clockCounterEn;
    hostPkg::busReq_t         busReq;
    logic [15:0]              rdData;
    demodPkg::legacyStream_t  legacy;
    demodPkg::trellisStream_t pcmTrellis;
    demodPkg::trellisStream_t soqpskTrellis;
    demodPkg::lockStatus_t    lockStatus;
    demodPkg::dacSample_t     demodSample [3];
    demodPkg::dacSample_t     pcmTrellisSample [3];
    demodPkg::dacSample_t     soqpskTrellisSample [3];
    demodPkg::multihSample_t  multihSample [3];
    demodPkg::dataOut_t       dataOut;
    demodPkg::lockOut_t       lockOut;
    demodPkg::demodMode_t     demodMode;
    logic                     coreReset;
    logic [13:0]              dacData [3];
    int                       seed = 56;
    int                       errorCount = 0;
    int                       checkCount = 0;
    int                       cycleCount = 0;

    `include "demodShellModel.svh"

    demodOutputShell DUT (.*);

    always #2 ck933 = ~ck933;

    function automatic int randomBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic hostPkg::busReq_t busWrite(input logic [5:0] space,
                                                 input logic [3:0] offset,
                                                 input logic [15:0] data);
        hostPkg::busReq_t req;
        req        = '0;
        req.cs     = 1'b1;
        req.we     = 1'b1;
        req.addr   = {space, offset, 2'b00};
        req.wrData = data;
        return req;
    endfunction

    function automatic hostPkg::busReq_t busRead(input logic [5:0] space,
                                                input logic [3:0] offset, input logic hi);
        hostPkg::busReq_t req;
        req      = '0;
        req.cs   = 1'b1;
        req.rd   = 1'b1;
        req.addr = {space, offset, hi, 1'b0};
        return req;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h at cycle %0d",
                     name, expected, actual, cycleNum);
        end
    endtask

    task automatic checkOutputs();
        compareValue("rdData", expRdData, rdData);
        compareValue("coreReset", resetLeft > 0, coreReset);
        compareValue("dataOut", expDataOut, dataOut);
        compareValue("lockOut", expLockOut, lockOut);
        compareValue("demodMode", modelCfg.mode, demodMode);
        for (int ch = 0; ch < 3; ch++) begin
            compareValue($sformatf("dacData[%0d]", ch), expDac[ch], dacData[ch]);
        end
    endtask

    // Fresh random streams and samples every cycle
    task automatic driveStreams();
        logic [31:0] r;
        r             = $random(seed);
        legacy        = r[3:0];
        pcmTrellis    = r[6:4];
        soqpskTrellis = r[9:7];
        lockStatus    = r[12:10];
        for (int ch = 0; ch < 3; ch++) begin
            r = $random(seed);
            demodSample[ch] = r[18:0];
            r = $random(seed);
            pcmTrellisSample[ch] = r[18:0];
            r = $random(seed);
            soqpskTrellisSample[ch] = r[18:0];
            r = $random(seed);
            multihSample[ch] = r[19:0];
        end
    endtask

    // Check after the edge, then drive the next cycle
    task automatic runCycle(input hostPkg::busReq_t req);
        @(posedge ck933);
        #1;
        stepModel();
        checkOutputs();
        busReq = req;
        driveStreams();
    endtask

    initial begin
        logic [15:0] value;
        int          highCycles;
        clockCounterEn = 1'b1;
        busReq         = '0;
        legacy         = '0;
        pcmTrellis     = '0;
        soqpskTrellis  = '0;
        lockStatus     = '0;
        for (int ch = 0; ch < 3; ch++) begin
            demodSample[ch]         = '0;
            pcmTrellisSample[ch]    = '0;
            soqpskTrellisSample[ch] = '0;
            multihSample[ch]        = '0;
        end
        resetModel();
        repeat (10) @(posedge ck933);
        #1;
        clockCounterEn = 1'b0;

        // ****************************************
        // Register map
        // ****************************************
        runCycle(busRead(hostPkg::MISC_SPACE, hostPkg::MISC_VERSION, 1'b1));
        runCycle(busRead(hostPkg::MISC_SPACE, hostPkg::MISC_VERSION, 1'b0));
        repeat (10) begin
            for (int r = 0; r < 4; r++) begin
                value = $random(seed);
                if (r == 0) begin
                    value[3:0] = 4'(randomBelow(9));
                end
                runCycle(busWrite(hostPkg::CONFIG_SPACE, 4'(r), value));
            end
            for (int r = 0; r < 8; r++) begin
                runCycle(busRead(hostPkg::CONFIG_SPACE, 4'(r / 2), r[0]));
            end
        end
        // Unmapped spaces and offsets
        repeat (20) begin
            runCycle(busRead(6'(randomBelow(61) + 2), 4'(randomBelow(16)), randomBelow(2)));
            runCycle(busRead(hostPkg::CONFIG_SPACE, 4'(4 + randomBelow(12)), 1'b0));
            runCycle(busRead(hostPkg::MISC_SPACE, 4'(3 + randomBelow(13)), randomBelow(2)));
        end

        // Clock counter restart then read
        repeat (20) begin
            repeat (randomBelow(16)) runCycle('0);
            runCycle(busWrite(hostPkg::MISC_SPACE, hostPkg::MISC_CLOCK, 16'h0000));
            repeat (randomBelow(32)) runCycle('0);
            runCycle(busRead(hostPkg::MISC_SPACE, hostPkg::MISC_CLOCK, 1'b0));
            runCycle(busRead(hostPkg::MISC_SPACE, hostPkg::MISC_CLOCK, 1'b1));
        end

        // Software reset length
        repeat (10) begin
            runCycle(busWrite(hostPkg::CONFIG_SPACE, hostPkg::CFG_MODE, 16'(randomBelow(9))));
            repeat (4) runCycle('0);
            runCycle(busWrite(hostPkg::MISC_SPACE, hostPkg::MISC_RESET, 16'h0001));
            highCycles = 0;
            repeat (STRETCH_CYCLES + 4) begin
                runCycle('0);
                highCycles += coreReset;
            end
            compareValue("coreReset high cycles", STRETCH_CYCLES, highCycles);
        end

        // ****************************************
        // Data and lock selection per mode
        // ****************************************
        for (int m = 0; m < 9; m++) begin
            runCycle(busWrite(hostPkg::CONFIG_SPACE, hostPkg::CFG_MODE, 16'(m)));
            repeat (100) runCycle('0);
        end

        // DAC routing with random selects
        repeat (40) begin
            runCycle(busWrite(hostPkg::CONFIG_SPACE, hostPkg::CFG_MODE, 16'(randomBelow(9))));
            for (int d = 1; d < 4; d++) begin
                runCycle(busWrite(hostPkg::CONFIG_SPACE, 4'(d), 16'(randomBelow(16))));
            end
            repeat (8) runCycle('0);
        end
        repeat (3) runCycle('0);

        $display("Errors: %0d mismatches in %0d compares", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge ck933);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d mismatches in %0d compares", errorCount, checkCount);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+tb
rtl/hostPkg.sv
rtl/demodPkg.sv
rtl/hostRegs.sv
rtl/miscSpace.sv
rtl/dataOutputSelect.sv
rtl/dacChannelMux.sv
rtl/demodOutputShell.sv
tb/demodShellTb.sv
